// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_energy_monitor -f sim.f \
		--Mdir obj_dir -o tb_energy_monitor
	./obj_dir/tb_energy_monitor > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/em_cfg_pkg.sv
`default_nettype none

package em_cfg_pkg;

    // spin vector and row grouping
    localparam int NUM_SPIN = 16;
    localparam int PARALLELISM = 2;
    localparam int SPINIDX_BIT = $clog2(NUM_SPIN);

    // coefficient precision, J and h are signed, the scaling is unsigned
    localparam int BITJ = 4;
    localparam int BITH = 4;
    localparam int SCALING_BIT = 4;

    // bus widths, row 0 always sits in the low slice
    localparam int ROW_WEIGHT_BIT = NUM_SPIN * BITJ;
    localparam int DATAJ = ROW_WEIGHT_BIT * PARALLELISM;
    localparam int DATAH = BITH * PARALLELISM;
    localparam int DATASCALING = SCALING_BIT * PARALLELISM;

    // one row peaks near +-370, so 12 bits leave headroom
    localparam int LOCAL_ENERGY_BIT = 12;

    // output energy and the doubled running sum behind it
    localparam int ENERGY_TOTAL_BIT = 32;
    localparam int ACCUM_BIT = ENERGY_TOTAL_BIT + 1;

endpackage

`default_nettype wire

// File: hw/em_ctrl_pkg.sv
`default_nettype none

package em_ctrl_pkg;

    // sequencer states
    //  S_IDLE   waits for config or a spin vector
    //  S_SWEEP  takes weight beats
    //  S_DRAIN  waits for the last row results to settle
    //  S_OUTPUT holds the energy until it is taken
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SWEEP  = 2'd1,
        S_DRAIN  = 2'd2,
        S_OUTPUT = 2'd3
    } ctrl_state_t;

    // first row of the final group in a sweep
    localparam int LAST_GROUP = em_cfg_pkg::NUM_SPIN - em_cfg_pkg::PARALLELISM;

endpackage

`default_nettype wire

// File: hw/energy_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module energy_accumulator (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  logic                                           row_valid_i,
    input  logic signed [em_cfg_pkg::LOCAL_ENERGY_BIT-1:0] row_energy_0_i,
    input  logic signed [em_cfg_pkg::LOCAL_ENERGY_BIT-1:0] row_energy_1_i,
    input  logic                                           last_i,
    input  logic                                           clear_i,
    output logic signed [em_cfg_pkg::ENERGY_TOTAL_BIT-1:0] energy_o,
    output logic                                           done_o
);
    import em_cfg_pkg::*;

    logic signed [ACCUM_BIT-1:0] sum_q;
    logic signed [ACCUM_BIT-1:0] row_0_ext;
    logic signed [ACCUM_BIT-1:0] row_1_ext;
    logic signed [ACCUM_BIT-1:0] sum_next;
    logic signed [ACCUM_BIT-1:0] half_sum;
    logic signed [ACCUM_BIT-1:0] energy_neg;
    logic                        last_q;
    logic                        finish;

    // last beat flag lines up with the registered row results
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q <= 1'b0;
        end else begin
            last_q <= last_i;
        end
    end

    assign row_0_ext = ACCUM_BIT'(row_energy_0_i);
    assign row_1_ext = ACCUM_BIT'(row_energy_1_i);
    assign sum_next  = sum_q + row_0_ext + row_1_ext;

    // every pair is counted twice, signed divide truncates toward zero
    assign half_sum   = sum_next / 2;
    assign energy_neg = -half_sum;
    assign finish     = row_valid_i && last_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            sum_q <= '0;
        end else if (row_valid_i) begin
            sum_q <= sum_next;
        end
    end

    // result stays put until the next sweep closes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            energy_o <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= finish;
            if (finish) begin
                energy_o <= $signed(energy_neg[ENERGY_TOTAL_BIT-1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/energy_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module energy_monitor (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  logic                                           config_valid_i,
    input  logic [em_cfg_pkg::SPINIDX_BIT-1:0]             config_counter_i,
    output logic                                           config_ready_o,
    input  logic                                           spin_valid_i,
    input  logic [em_cfg_pkg::NUM_SPIN-1:0]                spin_i,
    output logic                                           spin_ready_o,
    input  logic                                           weight_valid_i,
    input  logic [em_cfg_pkg::DATAJ-1:0]                   weight_i,
    input  logic [em_cfg_pkg::DATAH-1:0]                   hbias_i,
    input  logic [em_cfg_pkg::DATASCALING-1:0]             hscaling_i,
    output logic                                           weight_ready_o,
    output logic [em_cfg_pkg::SPINIDX_BIT-1:0]             counter_spin_o,
    output logic                                           energy_valid_o,
    input  logic                                           energy_ready_i,
    output logic signed [em_cfg_pkg::ENERGY_TOTAL_BIT-1:0] energy_o,
    output logic                                           busy_o
);
    import em_cfg_pkg::*;

    logic                               load;
    logic                               beat;
    logic                               beat_last;
    logic                               clear;
    logic                               last_group;
    logic                               done;
    logic [NUM_SPIN-1:0]                spin_vector;
    logic [PARALLELISM-1:0]             current_spin;
    logic signed [LOCAL_ENERGY_BIT-1:0] row_energy_0;
    logic signed [LOCAL_ENERGY_BIT-1:0] row_energy_1;
    logic                               row_valid_0;
    logic                               row_valid_1;

    monitor_ctrl u_monitor_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .config_valid_i (config_valid_i),
        .config_ready_o (config_ready_o),
        .spin_valid_i   (spin_valid_i),
        .spin_ready_o   (spin_ready_o),
        .weight_valid_i (weight_valid_i),
        .weight_ready_o (weight_ready_o),
        .energy_ready_i (energy_ready_i),
        .energy_valid_o (energy_valid_o),
        .busy_o         (busy_o),
        .last_group_i   (last_group),
        .done_i         (done),
        .load_o         (load),
        .beat_o         (beat),
        .beat_last_o    (beat_last),
        .clear_o        (clear)
    );

    spin_cache u_spin_cache (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .config_valid_i   (config_valid_i),
        .config_ready_i   (config_ready_o),
        .config_counter_i (config_counter_i),
        .load_i           (load),
        .spin_i           (spin_i),
        .beat_i           (beat),
        .clear_i          (clear),
        .spin_vector_o    (spin_vector),
        .current_spin_o   (current_spin),
        .counter_o        (counter_spin_o),
        .last_group_o     (last_group)
    );

    // row 0 takes the low slice of every bus
    energy_row_unit u_row_0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .beat_i         (beat),
        .spin_vector_i  (spin_vector),
        .current_spin_i (current_spin[0]),
        .weight_i       (weight_i[0 +: ROW_WEIGHT_BIT]),
        .hbias_i        (hbias_i[0 +: BITH]),
        .hscaling_i     (hscaling_i[0 +: SCALING_BIT]),
        .row_energy_o   (row_energy_0),
        .row_valid_o    (row_valid_0)
    );

    energy_row_unit u_row_1 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .beat_i         (beat),
        .spin_vector_i  (spin_vector),
        .current_spin_i (current_spin[1]),
        .weight_i       (weight_i[ROW_WEIGHT_BIT +: ROW_WEIGHT_BIT]),
        .hbias_i        (hbias_i[BITH +: BITH]),
        .hscaling_i     (hscaling_i[SCALING_BIT +: SCALING_BIT]),
        .row_energy_o   (row_energy_1),
        .row_valid_o    (row_valid_1)
    );

    // both rows share one beat, so their valids move together
    energy_accumulator u_energy_accumulator (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .row_valid_i    (row_valid_0 && row_valid_1),
        .row_energy_0_i (row_energy_0),
        .row_energy_1_i (row_energy_1),
        .last_i         (beat_last),
        .clear_i        (clear),
        .energy_o       (energy_o),
        .done_o         (done)
    );

endmodule

`default_nettype wire

// File: hw/energy_row_unit.sv
`timescale 1ns/1ps
`default_nettype none

module energy_row_unit (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic                                       beat_i,
    input  logic [em_cfg_pkg::NUM_SPIN-1:0]            spin_vector_i,
    input  logic                                       current_spin_i,
    input  logic [em_cfg_pkg::ROW_WEIGHT_BIT-1:0]      weight_i,
    input  logic signed [em_cfg_pkg::BITH-1:0]         hbias_i,
    input  logic [em_cfg_pkg::SCALING_BIT-1:0]         hscaling_i,
    output logic signed [em_cfg_pkg::LOCAL_ENERGY_BIT-1:0] row_energy_o,
    output logic                                       row_valid_o
);
    import em_cfg_pkg::*;

    logic signed [LOCAL_ENERGY_BIT-1:0] dot_sum;
    logic signed [LOCAL_ENERGY_BIT-1:0] bias_term;
    logic signed [LOCAL_ENERGY_BIT-1:0] field_sum;
    logic signed [LOCAL_ENERGY_BIT-1:0] local_energy;

    // couplings against the +-1 spins, bit 1 means +1
    always_comb begin
        logic signed [BITJ-1:0]             coup;
        logic signed [LOCAL_ENERGY_BIT-1:0] coup_ext;
        dot_sum = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            coup     = weight_i[j*BITJ +: BITJ];
            coup_ext = LOCAL_ENERGY_BIT'(coup);
            dot_sum  = spin_vector_i[j] ? dot_sum + coup_ext : dot_sum - coup_ext;
        end
    end

    // 2*h*k, the scaling is unsigned so it gets zero padding
    always_comb begin
        logic signed [LOCAL_ENERGY_BIT-1:0] h_ext;
        logic signed [LOCAL_ENERGY_BIT-1:0] k_ext;
        h_ext     = LOCAL_ENERGY_BIT'(hbias_i);
        k_ext     = $signed({{(LOCAL_ENERGY_BIT-SCALING_BIT){1'b0}}, hscaling_i});
        bias_term = (h_ext * k_ext) <<< 1;
    end

    assign field_sum    = dot_sum + bias_term;
    // own spin flips the sign of the whole row
    assign local_energy = current_spin_i ? field_sum : -field_sum;

    always_ff @(posedge clk_i) begin
        if (beat_i) begin
            row_energy_o <= local_energy;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            row_valid_o <= 1'b0;
        end else begin
            row_valid_o <= beat_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/monitor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module monitor_ctrl (
    input  logic clk_i,
    input  logic rst_i,
    input  logic config_valid_i,
    output logic config_ready_o,
    input  logic spin_valid_i,
    output logic spin_ready_o,
    input  logic weight_valid_i,
    output logic weight_ready_o,
    input  logic energy_ready_i,
    output logic energy_valid_o,
    output logic busy_o,
    input  logic last_group_i,
    input  logic done_i,
    output logic load_o,
    output logic beat_o,
    output logic beat_last_o,
    output logic clear_o
);
    import em_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        idle;

    assign idle = (state_q == S_IDLE);

    // a pending config wins over a spin vector in the same cycle,
    // so the new start row is already stored when the vector lands
    assign config_ready_o = idle;
    assign spin_ready_o   = idle && !config_valid_i;
    assign weight_ready_o = (state_q == S_SWEEP);
    assign energy_valid_o = (state_q == S_OUTPUT);
    assign busy_o         = !idle;

    assign load_o      = spin_valid_i && spin_ready_o;
    assign beat_o      = weight_valid_i && weight_ready_o;
    assign beat_last_o = beat_o && last_group_i;
    assign clear_o     = energy_valid_o && energy_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (load_o) begin
                    state_d = S_SWEEP;
                end
            end
            S_SWEEP: begin
                if (beat_last_o) begin
                    state_d = S_DRAIN;
                end
            end
            // row units and accumulator still busy with the tail beats
            S_DRAIN: begin
                if (done_i) begin
                    state_d = S_OUTPUT;
                end
            end
            S_OUTPUT: begin
                if (clear_o) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // done only comes back while the tail beats drain
    a_done_in_drain: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> state_q == S_DRAIN);

    // energy is offered a fixed three cycles after the last beat
    a_output_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        energy_valid_o && !$past(energy_valid_o) |-> $past(beat_last_o, 3));

endmodule

`default_nettype wire

// File: hw/spin_cache.sv
`timescale 1ns/1ps
`default_nettype none

module spin_cache (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             config_valid_i,
    input  logic                             config_ready_i,
    input  logic [em_cfg_pkg::SPINIDX_BIT-1:0] config_counter_i,
    input  logic                             load_i,
    input  logic [em_cfg_pkg::NUM_SPIN-1:0]    spin_i,
    input  logic                             beat_i,
    input  logic                             clear_i,
    output logic [em_cfg_pkg::NUM_SPIN-1:0]    spin_vector_o,
    output logic [em_cfg_pkg::PARALLELISM-1:0] current_spin_o,
    output logic [em_cfg_pkg::SPINIDX_BIT-1:0] counter_o,
    output logic                             last_group_o
);
    import em_cfg_pkg::*;
    import em_ctrl_pkg::*;

    logic [SPINIDX_BIT-1:0] start_q;
    logic [SPINIDX_BIT-1:0] counter_q;
    logic [NUM_SPIN-1:0]    spin_q;
    logic                   config_hs;

    assign config_hs = config_valid_i && config_ready_i;

    // start row for the next vector is 0 after reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q <= '0;
        end else if (config_hs) begin
            start_q <= config_counter_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            spin_q <= spin_i;
        end
    end

    // row group counter rewinds to the start row for each new vector
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            counter_q <= '0;
        end else if (load_i || clear_i) begin
            counter_q <= start_q;
        end else if (beat_i) begin
            counter_q <= counter_q + SPINIDX_BIT'(PARALLELISM);
        end
    end

    assign spin_vector_o  = spin_q;
    assign current_spin_o = spin_q[counter_q +: PARALLELISM];
    assign counter_o      = counter_q;
    assign last_group_o   = (counter_q == SPINIDX_BIT'(LAST_GROUP));

    // an odd start row would make the group slice run past the vector
    a_start_even: assert property (@(posedge clk_i) disable iff (rst_i)
        config_hs |-> !config_counter_i[0]);

    // the controller must stop taking beats once the last group is done
    a_stop_after_last: assert property (@(posedge clk_i) disable iff (rst_i)
        beat_i && last_group_o |=> !beat_i);

endmodule

`default_nettype wire

// File: sim.f
hw/em_cfg_pkg.sv
hw/em_ctrl_pkg.sv
hw/spin_cache.sv
hw/energy_row_unit.sv
hw/energy_accumulator.sv
hw/monitor_ctrl.sv
hw/energy_monitor.sv
tests/energy_checker.sv
tests/tb_energy_monitor.sv

// File: tests/energy_checker.sv
`timescale 1ns/1ps
`default_nettype none

module energy_checker (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  logic                                           config_valid_i,
    input  logic [em_cfg_pkg::SPINIDX_BIT-1:0]             config_counter_i,
    input  logic                                           config_ready_i,
    input  logic                                           spin_valid_i,
    input  logic [em_cfg_pkg::NUM_SPIN-1:0]                spin_i,
    input  logic                                           spin_ready_i,
    input  logic                                           weight_valid_i,
    input  logic [em_cfg_pkg::DATAJ-1:0]                   weight_i,
    input  logic [em_cfg_pkg::DATAH-1:0]                   hbias_i,
    input  logic [em_cfg_pkg::DATASCALING-1:0]             hscaling_i,
    input  logic                                           weight_ready_i,
    input  logic [em_cfg_pkg::SPINIDX_BIT-1:0]             counter_spin_i,
    input  logic                                           energy_valid_i,
    input  logic                                           energy_ready_i,
    input  logic signed [em_cfg_pkg::ENERGY_TOTAL_BIT-1:0] energy_i,
    input  logic                                           busy_i,
    output int                                             error_count_o,
    output int                                             check_count_o
);
    import em_cfg_pkg::*;

    int                  errors = 0;
    int                  checks = 0;
    int                  cycle = 0;
    int                  last_beat_cycle = 0;
    int                  start_row = 0;
    int                  row = 0;
    int                  beats = 0;
    int                  sum = 0;
    int                  energy_q = 0;
    logic [NUM_SPIN-1:0] spins = '0;
    logic                rst_q = 1'b0;
    logic                valid_q = 1'b0;
    logic                held_q = 1'b0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    function automatic int spin_value(input logic b);
        return b ? 1 : -1;
    endfunction

    // s_r * (sum of J_rj*s_j + 2*h_r*k_r)
    function automatic int row_energy(input logic [ROW_WEIGHT_BIT-1:0] j_row,
                                      input logic signed [BITH-1:0] h,
                                      input logic [SCALING_BIT-1:0] k, input int r);
        int field;
        field = 2 * int'(h) * int'(k);
        for (int j = 0; j < NUM_SPIN; j++) begin
            field += int'($signed(j_row[j*BITJ +: BITJ])) * spin_value(spins[j]);
        end
        return spin_value(spins[r]) * field;
    endfunction

    // inputs change just after the rising edge, so the falling edge sees settled values
    always @(negedge clk_i) begin
        cycle++;
        if (rst_i) begin
            start_row = 0;
            valid_q   = 1'b0;
            held_q    = 1'b0;
        end else begin
            if (rst_q) begin
                compare("config_ready_o", 1, int'(config_ready_i));
                compare("spin_ready_o", 1, int'(spin_ready_i));
                compare("busy_o", 0, int'(busy_i));
                compare("weight_ready_o", 0, int'(weight_ready_i));
                compare("energy_valid_o", 0, int'(energy_valid_i));
                compare("energy_o", 0, int'(energy_i));
            end
            // back-pressure from the previous cycle
            if (held_q) begin
                compare("energy_valid_o", 1, int'(energy_valid_i));
                compare("energy_o", energy_q, int'(energy_i));
                compare("spin_ready_o", 0, int'(spin_ready_i));
                compare("busy_o", 1, int'(busy_i));
            end
            if (energy_valid_i && !valid_q) begin
                compare("energy_valid_o delay", 3, cycle - last_beat_cycle);
                compare("weight beat count", (NUM_SPIN - start_row) / PARALLELISM, beats);
                compare("energy_o", -(sum / 2), int'(energy_i));
            end
            if (config_valid_i && config_ready_i) begin
                start_row = int'(config_counter_i);
            end
            if (spin_valid_i && spin_ready_i) begin
                spins = spin_i;
                row   = start_row;
                beats = 0;
                sum   = 0;
            end
            if (weight_valid_i && weight_ready_i) begin
                compare("counter_spin_o", row, int'(counter_spin_i));
                for (int p = 0; p < PARALLELISM; p++) begin
                    sum += row_energy(weight_i[p*ROW_WEIGHT_BIT +: ROW_WEIGHT_BIT],
                                      hbias_i[p*BITH +: BITH],
                                      hscaling_i[p*SCALING_BIT +: SCALING_BIT], row + p);
                end
                row += PARALLELISM;
                beats++;
                last_beat_cycle = cycle;
            end
            held_q   = energy_valid_i && !energy_ready_i;
            valid_q  = energy_valid_i;
            energy_q = int'(energy_i);
        end
        rst_q = rst_i;
    end

endmodule

`default_nettype wire

// File: tests/tb_energy_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_energy_monitor;
    import em_cfg_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int PORT_CONFIG = 0;
    localparam int PORT_SPIN   = 1;
    localparam int PORT_WEIGHT = 2;

    logic                               clk;
    logic                               rst;
    logic                               config_valid;
    logic [SPINIDX_BIT-1:0]             config_counter;
    logic                               config_ready;
    logic                               spin_valid;
    logic [NUM_SPIN-1:0]                spin;
    logic                               spin_ready;
    logic                               weight_valid;
    logic [DATAJ-1:0]                   weight;
    logic [DATAH-1:0]                   hbias;
    logic [DATASCALING-1:0]             hscaling;
    logic                               weight_ready;
    logic [SPINIDX_BIT-1:0]             counter_spin;
    logic                               energy_valid;
    logic                               energy_ready;
    logic signed [ENERGY_TOTAL_BIT-1:0] energy;
    logic                               busy;
    logic [31:0]                        lfsr;
    int                                 error_count;
    int                                 check_count;
    int                                 timeouts;

    energy_monitor u_energy_monitor (
        .clk_i            (clk),
        .rst_i            (rst),
        .config_valid_i   (config_valid),
        .config_counter_i (config_counter),
        .config_ready_o   (config_ready),
        .spin_valid_i     (spin_valid),
        .spin_i           (spin),
        .spin_ready_o     (spin_ready),
        .weight_valid_i   (weight_valid),
        .weight_i         (weight),
        .hbias_i          (hbias),
        .hscaling_i       (hscaling),
        .weight_ready_o   (weight_ready),
        .counter_spin_o   (counter_spin),
        .energy_valid_o   (energy_valid),
        .energy_ready_i   (energy_ready),
        .energy_o         (energy),
        .busy_o           (busy)
    );

    energy_checker u_energy_checker (
        .clk_i            (clk),
        .rst_i            (rst),
        .config_valid_i   (config_valid),
        .config_counter_i (config_counter),
        .config_ready_i   (config_ready),
        .spin_valid_i     (spin_valid),
        .spin_i           (spin),
        .spin_ready_i     (spin_ready),
        .weight_valid_i   (weight_valid),
        .weight_i         (weight),
        .hbias_i          (hbias),
        .hscaling_i       (hscaling),
        .weight_ready_i   (weight_ready),
        .counter_spin_i   (counter_spin),
        .energy_valid_i   (energy_valid),
        .energy_ready_i   (energy_ready),
        .energy_i         (energy),
        .busy_i           (busy),
        .error_count_o    (error_count),
        .check_count_o    (check_count)
    );

    always #5 clk = ~clk;

    // galois LFSR, one step per bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = next_bit();
        end
        return value;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        timeouts++;
        $display("timeout: %s never came after %0d cycles", what, WAIT_LIMIT);
        finish_run();
    endtask

    function automatic logic ready_of(input int port);
        case (port)
            PORT_CONFIG: return config_ready;
            PORT_SPIN:   return spin_ready;
            default:     return weight_ready;
        endcase
    endfunction

    // ready is looked at before the edge that completes the handshake
    task automatic wait_ready(input int port, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!ready_of(port)) begin
            t++;
            if (t > WAIT_LIMIT) begin
                stop_on_timeout(what);
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_config(input logic [SPINIDX_BIT-1:0] start);
        config_valid   = 1'b1;
        config_counter = start;
        wait_ready(PORT_CONFIG, "config_ready_o");
        config_valid = 1'b0;
    endtask

    task automatic take_energy();
        logic [127:0] r;
        int           t;
        int           stall;
        t = 0;
        @(negedge clk);
        while (!energy_valid) begin
            t++;
            if (t > WAIT_LIMIT) begin
                stop_on_timeout("energy_valid_o");
            end
            @(negedge clk);
        end
        r     = rand_bits(3);
        stall = int'(r[2:0]);
        @(posedge clk);
        #1;
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        energy_ready = 1'b1;
        @(posedge clk);
        #1;
        energy_ready = 1'b0;
    endtask

    // one spin vector, its weight beats and the energy read-back
    task automatic run_sweep(input int start, input logic gaps);
        logic [127:0] r;
        int           beats;
        int           gap;
        beats      = (NUM_SPIN - start) / PARALLELISM;
        r          = rand_bits(NUM_SPIN);
        spin       = r[NUM_SPIN-1:0];
        spin_valid = 1'b1;
        wait_ready(PORT_SPIN, "spin_ready_o");
        spin_valid = 1'b0;
        for (int b = 0; b < beats; b++) begin
            r   = rand_bits(2);
            gap = gaps ? int'(r[1:0]) : 0;
            if (gap > 0) begin
                weight_valid = 1'b0;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            weight       = rand_bits(DATAJ);
            r            = rand_bits(DATAH + DATASCALING);
            hbias        = r[DATAH-1:0];
            hscaling     = r[DATAH +: DATASCALING];
            weight_valid = 1'b1;
            wait_ready(PORT_WEIGHT, "weight_ready_o");
        end
        weight_valid = 1'b0;
        take_energy();
    endtask

    initial begin
        logic [127:0]           r;
        logic [SPINIDX_BIT-1:0] start;
        lfsr           = 32'h1a2a81b3;
        timeouts       = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        config_valid   = 1'b0;
        config_counter = '0;
        spin_valid     = 1'b0;
        spin           = '0;
        weight_valid   = 1'b0;
        weight         = '0;
        hbias          = '0;
        hscaling       = '0;
        energy_ready   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // full sweeps with idle cycles between beats
        for (int v = 0; v < 20; v++) begin
            run_sweep(0, 1'b1);
        end
        for (int v = 0; v < 4; v++) begin
            run_sweep(0, 1'b0);
        end
        // shorter sweeps from an even start row
        for (int v = 0; v < 8; v++) begin
            r     = rand_bits(4);
            start = {r[2:0], 1'b0};
            send_config(start);
            run_sweep(int'(start), r[3]);
        end
        finish_run();
    end

endmodule

`default_nettype wire
